// File: rtl/cpu_pkg.sv
package cpu_pkg;

  // program counter, instruction word and ram address widths
  localparam int PC_W    = 13;
  localparam int INSTR_W = 12;
  localparam int RAM_AW  = 8;

  // top field of the instruction, ir[11:8]
  // codes 13 and 14 are unnamed and decode as nop
  typedef enum logic [3:0] {
    OP_JP   = 4'h0,
    OP_JPC  = 4'h1,
    OP_JPNZ = 4'h2,
    OP_LDA  = 4'h3,
    OP_LDB  = 4'h4,
    OP_LDX  = 4'h5,
    OP_ALU  = 4'h6,
    OP_ADDI = 4'h7,
    OP_STM  = 4'h8,
    OP_LDM  = 4'h9,
    OP_LDK  = 4'hA,
    OP_OUT  = 4'hB,
    OP_INCX = 4'hC,
    NOP     = 4'hF
  } opcode_t;

  // alu function, ir[2:0] for OP_ALU
  // codes 6 and 7 leave a and the flags alone
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_ADC = 3'd1,
    ALU_SUB = 3'd2,
    ALU_AND = 3'd3,
    ALU_OR  = 3'd4,
    ALU_XOR = 3'd5
  } alu_op_t;

  // source for the a accumulator
  typedef enum logic [2:0] {
    A_NONE = 3'd0,
    A_IMM  = 3'd1,
    A_ALU  = 3'd2,
    A_RAM  = 3'd3,
    A_KEY  = 3'd4
  } a_sel_t;

  // update of the x index register
  typedef enum logic [1:0] {
    X_NONE = 2'd0,
    X_IMM  = 2'd1,
    X_INC  = 2'd2
  } x_sel_t;

  typedef struct packed {
    logic carry;
    logic zero;
  } flags_t;

  // per-step datapath controls, 16 bits
  typedef struct packed {
    logic    ir_load;
    logic    pc_inc;
    logic    pc_jump;
    a_sel_t  a_sel;
    logic    b_load;
    x_sel_t  x_sel;
    logic    flags_load;
    alu_op_t alu_op;
    logic    alu_src_imm;
    logic    ram_we;
    logic    out_we;
  } ctrl_t;

endpackage

// File: rtl/microcode_ctrl.sv
`timescale 1ns/1ps

module microcode_ctrl (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [cpu_pkg::INSTR_W-1:0] ir,
  input  cpu_pkg::flags_t             flags,
  output cpu_pkg::ctrl_t              ctrl,
  output logic                        instr_done
);
  import cpu_pkg::*;

  // step 0 address out, 1 fetch, 2 execute, 3 ram read back (ldm only)
  logic [1:0] step;
  logic [1:0] step_nxt;
  opcode_t    opcode;
  alu_op_t    alu_sel;
  logic       alu_valid;
  logic       post_inc;
  logic       is_ldm;
  logic       jump_taken;

  // instruction fields, only meaningful from step 2 on
  assign opcode    = opcode_t'(ir[11:8]);
  assign alu_sel   = alu_op_t'(ir[2:0]);
  assign alu_valid = (ir[2:0] < 3'd6);
  // bit 0 selects post-increment of x for stm and ldm
  assign post_inc  = ir[0];
  assign is_ldm    = (opcode == OP_LDM);

  // branch condition from the current flags
  always_comb begin
    case (opcode)
      OP_JP:   jump_taken = 1'b1;
      OP_JPC:  jump_taken = flags.carry;
      OP_JPNZ: jump_taken = ~flags.zero;
      default: jump_taken = 1'b0;
    endcase
  end

  // ldm stretches to a fourth step for the registered ram read
  always_comb begin
    case (step)
      2'd0:    step_nxt = 2'd1;
      2'd1:    step_nxt = 2'd2;
      2'd2:    step_nxt = is_ldm ? 2'd3 : 2'd0;
      default: step_nxt = 2'd0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      step <= 2'd0;
    end else begin
      step <= step_nxt;
    end
  end

  // last step of every instruction
  assign instr_done = (step == 2'd3) || ((step == 2'd2) && !is_ldm);

  always_comb begin
    ctrl        = '0;
    ctrl.a_sel  = A_NONE;
    ctrl.x_sel  = X_NONE;
    ctrl.alu_op = ALU_ADD;
    case (step)
      2'd1: begin
        // rom_data valid now
        ctrl.ir_load = 1'b1;
      end
      2'd2: begin
        // page jump or next word, ldm moves the pc one step later
        ctrl.pc_jump = jump_taken;
        ctrl.pc_inc  = !jump_taken && !is_ldm;
        case (opcode)
          OP_LDA: ctrl.a_sel = A_IMM;
          OP_LDB: ctrl.b_load = 1'b1;
          OP_LDX: ctrl.x_sel = X_IMM;
          OP_ALU: begin
            // spare alu codes behave as nop
            if (alu_valid) begin
              ctrl.alu_op     = alu_sel;
              ctrl.a_sel      = A_ALU;
              ctrl.flags_load = 1'b1;
            end
          end
          OP_ADDI: begin
            ctrl.alu_op      = ALU_ADD;
            ctrl.alu_src_imm = 1'b1;
            ctrl.a_sel       = A_ALU;
            ctrl.flags_load  = 1'b1;
          end
          OP_STM: begin
            // write uses the old x, increment lands on the same edge
            ctrl.ram_we = 1'b1;
            if (post_inc) begin
              ctrl.x_sel = X_INC;
            end
          end
          OP_LDK:  ctrl.a_sel = A_KEY;
          OP_OUT:  ctrl.out_we = 1'b1;
          OP_INCX: ctrl.x_sel = X_INC;
          NOP:     ;
          // jumps, ldm address phase and spare codes
          default: ;
        endcase
      end
      2'd3: begin
        // ram data back from the x presented in step 2
        ctrl.a_sel  = A_RAM;
        ctrl.pc_inc = 1'b1;
        if (post_inc) begin
          ctrl.x_sel = X_INC;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
  input  logic                        clk,
  input  logic                        arst_n,
  input  cpu_pkg::ctrl_t              ctrl,
  input  logic [cpu_pkg::INSTR_W-1:0] rom_data,
  input  logic [3:0]                  alu_res,
  input  cpu_pkg::flags_t             alu_flags,
  input  logic [3:0]                  ram_rd,
  input  logic [3:0]                  k0,
  output logic [cpu_pkg::INSTR_W-1:0] ir,
  output logic [cpu_pkg::PC_W-1:0]    pc,
  output logic [3:0]                  a,
  output logic [3:0]                  b,
  output logic [cpu_pkg::RAM_AW-1:0]  x,
  output cpu_pkg::flags_t             flags,
  output logic [3:0]                  port_out,
  output logic                        port_strobe
);
  import cpu_pkg::*;

  // instruction register, loaded on the fetch step only
  always_ff @(posedge clk) begin
    if (ctrl.ir_load) begin
      ir <= rom_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc          <= '0;
      a           <= 4'h0;
      b           <= 4'h0;
      x           <= '0;
      flags       <= '0;
      port_out    <= 4'h0;
      port_strobe <= 1'b0;
    end else begin
      // jump keeps the page, increment wraps at 8192
      if (ctrl.pc_jump) begin
        pc <= {pc[PC_W-1:8], ir[7:0]};
      end else if (ctrl.pc_inc) begin
        pc <= pc + PC_W'(1);
      end

      case (ctrl.a_sel)
        A_IMM:   a <= ir[3:0];
        A_ALU:   a <= alu_res;
        A_RAM:   a <= ram_rd;
        A_KEY:   a <= k0;
        default: a <= a;
      endcase

      if (ctrl.b_load) begin
        b <= ir[3:0];
      end

      case (ctrl.x_sel)
        X_IMM:   x <= ir[RAM_AW-1:0];
        X_INC:   x <= x + RAM_AW'(1);
        default: x <= x;
      endcase

      if (ctrl.flags_load) begin
        flags <= alu_flags;
      end

      // strobe lines up with the new port value
      if (ctrl.out_we) begin
        port_out <= a;
      end
      port_strobe <= ctrl.out_we;
    end
  end

endmodule

// File: rtl/nibble_alu.sv
`timescale 1ns/1ps

module nibble_alu (
  input  cpu_pkg::alu_op_t op,
  input  logic [3:0]       a,
  input  logic [3:0]       operand,
  input  logic             carry_in,
  output logic [3:0]       res,
  output cpu_pkg::flags_t  flags
);
  import cpu_pkg::*;

  logic [4:0] sum;
  logic [4:0] diff;
  logic       cin;
  logic       carry_out;

  // carry flag only feeds adc
  assign cin  = carry_in & (op == ALU_ADC);
  assign sum  = {1'b0, a} + {1'b0, operand} + {4'b0, cin};
  // bit 4 set on borrow
  assign diff = {1'b0, a} - {1'b0, operand};

  always_comb begin
    case (op)
      ALU_ADD, ALU_ADC: begin
        res       = sum[3:0];
        carry_out = sum[4];
      end
      ALU_SUB: begin
        res       = diff[3:0];
        carry_out = diff[4];
      end
      ALU_AND: begin
        res       = a & operand;
        carry_out = 1'b0;
      end
      ALU_OR: begin
        res       = a | operand;
        carry_out = 1'b0;
      end
      ALU_XOR: begin
        res       = a ^ operand;
        carry_out = 1'b0;
      end
      default: begin
        // spare codes pass a through, carry unchanged
        res       = a;
        carry_out = carry_in;
      end
    endcase
  end

  assign flags.carry = carry_out;
  assign flags.zero  = (res == 4'h0);

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
  input  logic                       clk,
  input  logic [cpu_pkg::RAM_AW-1:0] addr,
  input  logic [3:0]                 wr_data,
  input  logic                       we,
  output logic [3:0]                 rd_data
);
  import cpu_pkg::*;

  // 256 nibbles
  logic [3:0] mem [2**RAM_AW];

  // synchronous write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wr_data;
    end
  end

  // read data one cycle after the address, old value on a collision
  always_ff @(posedge clk) begin
    rd_data <= mem[addr];
  end

endmodule

// File: rtl/cpu_6s46.sv
`timescale 1ns/1ps

module cpu_6s46 (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [3:0]                  k0,
  output logic [cpu_pkg::PC_W-1:0]    rom_addr,
  input  logic [cpu_pkg::INSTR_W-1:0] rom_data,
  output logic [3:0]                  port_out,
  output logic                        port_strobe,
  output logic                        instr_done
);
  import cpu_pkg::*;

  ctrl_t              ctrl;
  flags_t             flags;
  flags_t             alu_flags;
  logic [INSTR_W-1:0] ir;
  logic [PC_W-1:0]    pc;
  logic [3:0]         a;
  logic [3:0]         b;
  logic [RAM_AW-1:0]  x;
  logic [3:0]         alu_res;
  logic [3:0]         operand;
  logic [3:0]         ram_rd;

  // pc is a register, so the rom address comes straight off a flop
  assign rom_addr = pc;

  // second alu operand, immediate nibble for addi
  assign operand = ctrl.alu_src_imm ? ir[3:0] : b;

  microcode_ctrl u_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .ir         (ir),
    .flags      (flags),
    .ctrl       (ctrl),
    .instr_done (instr_done)
  );

  reg_bank u_regs (
    .clk         (clk),
    .arst_n      (arst_n),
    .ctrl        (ctrl),
    .rom_data    (rom_data),
    .alu_res     (alu_res),
    .alu_flags   (alu_flags),
    .ram_rd      (ram_rd),
    .k0          (k0),
    .ir          (ir),
    .pc          (pc),
    .a           (a),
    .b           (b),
    .x           (x),
    .flags       (flags),
    .port_out    (port_out),
    .port_strobe (port_strobe)
  );

  nibble_alu u_alu (
    .op       (ctrl.alu_op),
    .a        (a),
    .operand  (operand),
    .carry_in (flags.carry),
    .res      (alu_res),
    .flags    (alu_flags)
  );

  // x addresses the ram, a is the store data
  data_ram u_ram (
    .clk     (clk),
    .addr    (x),
    .wr_data (a),
    .we      (ctrl.ram_we),
    .rd_data (ram_rd)
  );

endmodule

// File: test/microcode_ctrl_assert.sv
`timescale 1ns/1ps

module microcode_ctrl_assert (
  input logic                        clk,
  input logic                        arst_n,
  input logic [1:0]                  step,
  input logic [cpu_pkg::INSTR_W-1:0] ir,
  input cpu_pkg::ctrl_t              ctrl,
  input logic                        instr_done
);
  import cpu_pkg::*;

  // done never lasts two cycles
  done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    instr_done |=> !instr_done)
    else $error("instr_done held for more than one cycle");

  // side effects on execute only
  ram_we_step: assert property (@(posedge clk) disable iff (!arst_n)
    ctrl.ram_we |-> (step == 2'd2))
    else $error("ram_we outside the execute step");

  out_we_step: assert property (@(posedge clk) disable iff (!arst_n)
    ctrl.out_we |-> (step == 2'd2))
    else $error("out_we outside the execute step");

  // a fourth step belongs to ldm alone
  ldm_step: assert property (@(posedge clk) disable iff (!arst_n)
    (step == 2'd3) |-> (ir[11:8] == OP_LDM))
    else $error("fourth step on an instruction other than ldm");

endmodule

bind microcode_ctrl microcode_ctrl_assert u_ctrl_chk (
  .clk        (clk),
  .arst_n     (arst_n),
  .step       (step),
  .ir         (ir),
  .ctrl       (ctrl),
  .instr_done (instr_done)
);

// File: test/cpu_6s46_tb.sv
`timescale 1ns/1ps

module cpu_6s46_tb;
  import cpu_pkg::*;

  // instruction-level model state
  typedef struct packed {
    logic [PC_W-1:0]   pc;
    logic [3:0]        a;
    logic [3:0]        b;
    logic [RAM_AW-1:0] x;
    logic              carry;
    logic              zero;
    logic [3:0]        port;
    logic              strobe;
    logic              we;
    logic [RAM_AW-1:0] waddr;
    logic [3:0]        wdata;
  } model_t;

  // one full trip through rom plus a second pass over the directed part
  localparam int N_EXEC = 8192 + 40;
  localparam int LIMIT  = 4 * N_EXEC + 200;

  logic               clk;
  logic               arst_n;
  logic [3:0]         k0;
  logic [PC_W-1:0]    rom_addr;
  logic [INSTR_W-1:0] rom_data;
  logic [3:0]         port_out;
  logic               port_strobe;
  logic               instr_done;

  logic [INSTR_W-1:0] rom [2**PC_W];
  logic [3:0]         m_ram [2**RAM_AW];
  logic [23:0]        lfsr_q;
  model_t             m;
  int                 wp;
  int                 n_exec;
  int                 errors;
  int                 checks;
  int                 cycles;
  int                 last_done;
  logic               check_next;

  cpu_6s46 dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .k0          (k0),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .port_out    (port_out),
    .port_strobe (port_strobe),
    .instr_done  (instr_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // taps 24 23 22 17
  function automatic logic [23:0] lfsr_step(logic [23:0] s);
    return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
  endfunction

  task automatic take_bits(input int n, output logic [11:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[10:0], lfsr_q[23]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic emit(input logic [3:0] op, input logic [7:0] imm);
    rom[wp] = {op, imm};
    wp++;
  endtask

  task automatic report_mismatch(input string name, input int exp, input int act);
    $display("Mismatch %s: expected %0h actual %0h", name, exp, act);
    errors++;
  endtask

  // expected state after one instruction
  function automatic model_t ref_step(model_t s, logic [11:0] instr, logic [3:0] k,
                                      logic [3:0] rd);
    model_t     n;
    logic [4:0] t;
    logic [7:0] imm;
    n        = s;
    imm      = instr[7:0];
    n.strobe = 1'b0;
    n.we     = 1'b0;
    n.pc     = s.pc + 13'd1;
    case (instr[11:8])
      4'h0: n.pc = {s.pc[12:8], imm};
      4'h1: if (s.carry) n.pc = {s.pc[12:8], imm};
      4'h2: if (!s.zero) n.pc = {s.pc[12:8], imm};
      4'h3: n.a = imm[3:0];
      4'h4: n.b = imm[3:0];
      4'h5: n.x = imm;
      4'h6: begin
        if (instr[2:0] < 3'd6) begin
          case (instr[2:0])
            3'd0: t = {1'b0, s.a} + {1'b0, s.b};
            3'd1: t = {1'b0, s.a} + {1'b0, s.b} + {4'b0, s.carry};
            3'd2: t = {1'b0, s.a} - {1'b0, s.b};
            3'd3: t = {1'b0, s.a & s.b};
            3'd4: t = {1'b0, s.a | s.b};
            default: t = {1'b0, s.a ^ s.b};
          endcase
          n.a     = t[3:0];
          n.carry = t[4];
          n.zero  = (t[3:0] == 4'h0);
        end
      end
      4'h7: begin
        t       = {1'b0, s.a} + {1'b0, imm[3:0]};
        n.a     = t[3:0];
        n.carry = t[4];
        n.zero  = (t[3:0] == 4'h0);
      end
      4'h8: begin
        n.we    = 1'b1;
        n.waddr = s.x;
        n.wdata = s.a;
        if (instr[0]) n.x = s.x + 8'd1;
      end
      4'h9: begin
        n.a = rd;
        if (instr[0]) n.x = s.x + 8'd1;
      end
      4'hA: n.a = k;
      4'hB: begin
        n.port   = s.a;
        n.strobe = 1'b1;
      end
      4'hC: n.x = s.x + 8'd1;
      default: ;
    endcase
    return n;
  endfunction

  task automatic build_program();
    logic [11:0] v1;
    logic [11:0] v2;
    logic [11:0] r;
    wp = 0;
    // add with carry out, then taken jc and untaken jnz
    emit(4'h3, 8'h09);
    emit(4'h4, 8'h07);
    emit(4'h6, 8'h00);
    emit(4'hB, 8'h00);
    emit(4'h1, 8'(wp + 2));
    emit(4'hB, 8'h00);
    emit(4'h5, 8'h10);
    emit(4'hF, 8'h00);
    emit(4'h2, 8'(wp + 2));
    emit(4'hB, 8'h00);
    // store four nibbles with post-increment
    for (int i = 0; i < 4; i++) begin
      take_bits(4, v1);
      emit(4'h3, v1[7:0]);
      emit(4'h8, 8'h01);
    end
    // read them back in order
    emit(4'h5, 8'h10);
    for (int i = 0; i < 4; i++) begin
      emit(4'h9, 8'h01);
      emit(4'hB, 8'h00);
    end
    // key echo
    for (int i = 0; i < 3; i++) begin
      emit(4'hA, 8'h00);
      emit(4'hB, 8'h00);
    end
    // every alu code, spare ones too, then flag-driven jumps
    for (int op = 0; op < 8; op++) begin
      take_bits(4, v1);
      take_bits(4, v2);
      emit(4'h3, v1[7:0]);
      emit(4'h4, v2[7:0]);
      emit(4'h6, 8'(op));
      emit(4'hB, 8'h00);
      emit(4'h1, 8'(wp + 2));
      emit(4'hB, 8'h00);
      emit(4'h5, v2[7:0]);
      emit(4'h2, 8'(wp + 2));
      emit(4'hB, 8'h00);
    end
    // spare codes d, e, f with an address-dependent immediate
    for (int ad = wp; ad < 2**PC_W; ad++) begin
      rom[ad] = {4'(13 + ad % 3), 8'(ad) ^ 8'(ad >> 5)};
    end
    // random block in the last page, jumps only go forward
    for (int ad = 'h1F00; ad < 'h1FF0; ad++) begin
      take_bits(4, r);
      if (r[3:0] == 4'h9) r[3:0] = 4'hA;
      take_bits(8, v1);
      if (r[3:0] <= 4'h2) v1[7:0] = 8'(ad) + 8'd1 + {4'h0, v1[3:0]};
      rom[ad] = {r[3:0], v1[7:0]};
    end
    // both outcomes land on 8191, which then wraps to 0
    rom['h1FFE] = {4'h1, 8'hFF};
  endtask

  // registered rom read
  always @(negedge clk) begin
    rom_data <= rom[rom_addr];
  end

  always @(negedge clk) begin : compare
    logic [11:0] instr;
    logic [11:0] kv;
    int          want;
    if (arst_n) begin
      cycles++;
      if (check_next) begin
        check_next = 1'b0;
        checks++;
        if (rom_addr !== m.pc) report_mismatch("pc", int'(m.pc), int'(rom_addr));
        if (m.strobe) begin
          if (port_strobe !== 1'b1) begin
            $display("port_strobe missing after OUT at model pc %0h", m.pc);
            errors++;
          end
          if (port_out !== m.port) report_mismatch("port", int'(m.port), int'(port_out));
        end else if (port_strobe !== 1'b0) begin
          $display("port_strobe raised without an OUT, model pc %0h", m.pc);
          errors++;
        end
        // fresh key value for the next instruction
        take_bits(4, kv);
        k0 <= kv[3:0];
      end
      if (instr_done === 1'b1) begin
        instr = rom[m.pc];
        want  = (instr[11:8] == 4'h9) ? 4 : 3;
        if (n_exec > 0 && cycles - last_done != want) begin
          report_mismatch("cycles", want, cycles - last_done);
        end
        last_done = cycles;
        m = ref_step(m, instr, k0, m_ram[m.x]);
        if (m.we) m_ram[m.waddr] = m.wdata;
        n_exec++;
        check_next = 1'b1;
      end else if (n_exec == 0) begin
        // still inside the first fetch
        if (rom_addr !== '0) report_mismatch("reset_pc", 0, int'(rom_addr));
        if (port_strobe !== 1'b0) begin
          $display("port_strobe high before the first instruction");
          errors++;
        end
      end
    end
  end

  initial begin : main
    int cyc;
    logic [11:0] kv;
    arst_n     = 1'b0;
    k0         = 4'h0;
    rom_data   = '0;
    lfsr_q     = 24'd91164;
    m          = '0;
    n_exec     = 0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    last_done  = 0;
    check_next = 1'b0;
    build_program();
    take_bits(4, kv);
    k0 = kv[3:0];
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    cyc = 0;
    while ((n_exec < N_EXEC || check_next) && cyc < LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    if (cyc >= LIMIT) begin
      $display("timeout after %0d cycles with %0d instructions done", cyc, n_exec);
      errors++;
    end
    $display("instructions %0d checks %0d errors %0d", n_exec, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: list.f
rtl/cpu_pkg.sv
rtl/microcode_ctrl.sv
rtl/reg_bank.sv
rtl/nibble_alu.sv
rtl/data_ram.sv
rtl/cpu_6s46.sv
test/microcode_ctrl_assert.sv
test/cpu_6s46_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cpu_6s46 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cpu_6s46_tb -o cpu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/cpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
